//--- npc_pkg.sv
package npc_pkg;

    // rv32 only
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    // funct3 values for the supported subset
    localparam logic [2:0] f3_add  = 3'b000;   // add, sub, addi, jalr
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;   // lw, sw

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // full encoding, no operands
    localparam word_t ebreak_word = 32'h0010_0073;

    typedef enum logic [3:0] {
        inv,
        lui,
        auipc,
        addi,
        add,
        sub,
        jal,
        jalr,
        beq,
        bne,
        lw,
        sw,
        ebreak
    } inst_num_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_eq,
        alu_passb
    } alu_func_e;

    typedef struct packed {
        inst_num_e inst_num;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;   // already sign extended
    } inst_dec_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        word_t    data;
    } gpr_wr_t;

    typedef struct packed {
        logic  en;
        word_t addr;
        word_t data;
    } mem_wr_t;

endpackage

//--- npc_idu.sv
`timescale 1ns/1ps

module npc_idu
    (
        input  npc_pkg::word_t     inst,
        output npc_pkg::inst_dec_t dec
    );

    import npc_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb
    begin
        // register fields pass straight through, exu decides what gets used
        dec.rd       = inst[11:7];
        dec.rs1      = inst[19:15];
        dec.rs2      = inst[24:20];
        dec.inst_num = inv;
        dec.imm      = '0;
        case (opcode)
            op_lui:
            begin
                dec.inst_num = lui;
                dec.imm      = imm_u;
            end
            op_auipc:
            begin
                dec.inst_num = auipc;
                dec.imm      = imm_u;
            end
            op_imm:
            begin
                dec.imm = imm_i;
                if (funct3 == f3_add)
                    dec.inst_num = addi;
            end
            op_reg:
            begin
                if (funct3 == f3_add && funct7 == f7_base)
                    dec.inst_num = add;
                else if (funct3 == f3_add && funct7 == f7_alt)
                    dec.inst_num = sub;
            end
            op_jal:
            begin
                dec.inst_num = jal;
                dec.imm      = imm_j;
            end
            op_jalr:
            begin
                dec.imm = imm_i;
                if (funct3 == f3_add)
                    dec.inst_num = jalr;
            end
            op_branch:
            begin
                dec.imm = imm_b;
                if (funct3 == f3_beq)
                    dec.inst_num = beq;
                else if (funct3 == f3_bne)
                    dec.inst_num = bne;
            end
            op_load:
            begin
                dec.imm = imm_i;
                if (funct3 == f3_word)
                    dec.inst_num = lw;
            end
            op_store:
            begin
                dec.imm = imm_s;
                if (funct3 == f3_word)
                    dec.inst_num = sw;
            end
            default:
            begin
                if (inst == ebreak_word)   // system opcode, exact match only
                    dec.inst_num = ebreak;
            end
        endcase
    end

endmodule

//--- npc_gpr.sv
`timescale 1ns/1ps

module npc_gpr
    (
        input  logic               clk,
        input  logic               reset,
        input  npc_pkg::reg_idx_t  rs1,
        input  npc_pkg::reg_idx_t  rs2,
        output npc_pkg::word_t     src1,
        output npc_pkg::word_t     src2,
        input  npc_pkg::gpr_wr_t   gpr_wr
    );

    import npc_pkg::*;

    word_t regs [1:31];   // x0 has no storage

    assign src1 = (rs1 == '0) ? '0 : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (gpr_wr.en && gpr_wr.rd != '0)
        begin
            regs[gpr_wr.rd] <= gpr_wr.data;
        end
    end

    // exu must never hand over a write without a clean destination
    a_wr_rd_known: assert property (
        @(posedge clk) disable iff (reset)
        gpr_wr.en |-> !$isunknown(gpr_wr.rd)
    );

endmodule

//--- npc_alu.sv
`timescale 1ns/1ps

module npc_alu
    (
        input  npc_pkg::word_t     alu_a,
        input  npc_pkg::word_t     alu_b,
        input  npc_pkg::alu_func_e alu_func,
        output npc_pkg::word_t     alu_result
    );

    import npc_pkg::*;

    word_t sum;
    word_t diff;

    assign sum  = alu_a + alu_b;
    assign diff = alu_a - alu_b;   // wraps at 32 bits

    always_comb
    begin
        case (alu_func)
            alu_add:
                alu_result = sum;
            alu_sub:
                alu_result = diff;
            alu_eq:
                alu_result = {{(xlen-1){1'b0}}, diff == '0};
            alu_passb:
                alu_result = alu_b;   // lui
            default:
                alu_result = 'x;
        endcase
    end

endmodule

//--- npc_exu.sv
`timescale 1ns/1ps

module npc_exu
    #(
        parameter npc_pkg::word_t reset_pc = 32'h8000_0000
    )
    (
        input  logic               clk,
        input  logic               reset,
        input  npc_pkg::inst_dec_t dec,
        input  npc_pkg::word_t     src1,
        input  npc_pkg::word_t     src2,
        output npc_pkg::word_t     alu_a,
        output npc_pkg::word_t     alu_b,
        output npc_pkg::alu_func_e alu_func,
        input  npc_pkg::word_t     alu_result,
        output npc_pkg::word_t     mem_r_addr,
        input  npc_pkg::word_t     mem_r,
        output npc_pkg::gpr_wr_t   gpr_wr,
        output npc_pkg::mem_wr_t   mem_wr,
        output npc_pkg::word_t     pc,
        output logic               halted
    );

    import npc_pkg::*;

    word_t pc_plus4;
    word_t next_pc;
    logic  taken;
    logic  writes_rd;

    assign pc_plus4 = pc + 32'd4;

    always_comb
    begin
        alu_a    = src1;
        alu_b    = dec.imm;
        alu_func = alu_add;
        case (dec.inst_num)
            lui:
                alu_func = alu_passb;
            auipc, jal:
                alu_a = pc;   // pc relative
            add:
                alu_b = src2;
            sub:
            begin
                alu_b    = src2;
                alu_func = alu_sub;
            end
            beq, bne:
            begin
                alu_b    = src2;
                alu_func = alu_eq;
            end
            default:
                ;   // addi, jalr, lw, sw: src1 + imm
        endcase
    end

    assign taken = (dec.inst_num == beq &&  alu_result[0]) ||
                   (dec.inst_num == bne && !alu_result[0]);

    always_comb
    begin
        if (dec.inst_num == jal)
            next_pc = alu_result;
        else if (dec.inst_num == jalr)
            next_pc = {alu_result[xlen-1:1], 1'b0};
        else if (taken)
            next_pc = pc + dec.imm;
        else
            next_pc = pc_plus4;   // also inv
    end

    always_comb
    begin
        case (dec.inst_num)
            lui, auipc, addi, add, sub, jal, jalr, lw:
                writes_rd = 1'b1;
            default:
                writes_rd = 1'b0;
        endcase
    end

    assign mem_r_addr = alu_result;

    assign gpr_wr.en   = writes_rd && !halted && !reset;
    assign gpr_wr.rd   = dec.rd;
    assign gpr_wr.data = (dec.inst_num == jal || dec.inst_num == jalr) ? pc_plus4 :
                         (dec.inst_num == lw)                          ? mem_r    :
                                                                         alu_result;

    assign mem_wr.en   = (dec.inst_num == sw) && !halted && !reset;
    assign mem_wr.addr = alu_result;
    assign mem_wr.data = src2;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end
        else if (!halted)
        begin
            pc <= next_pc;
            if (dec.inst_num == ebreak)
                halted <= 1'b1;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    );

endmodule

//--- npc_dmem.sv
`timescale 1ns/1ps

module npc_dmem
    #(
        parameter int dmem_words = 256
    )
    (
        input  logic             clk,
        input  npc_pkg::word_t   mem_r_addr,
        output npc_pkg::word_t   mem_r,
        input  npc_pkg::mem_wr_t mem_wr
    );

    import npc_pkg::*;

    localparam int idx_bits = $clog2(dmem_words);

    word_t mem [dmem_words];

    logic [idx_bits-1:0] r_idx;
    logic [idx_bits-1:0] w_idx;

    // word index, upper address bits wrap
    assign r_idx = mem_r_addr[idx_bits+1:2];
    assign w_idx = mem_wr.addr[idx_bits+1:2];

    assign mem_r = mem[r_idx];

    always_ff @(posedge clk)
    begin
        if (mem_wr.en)
            mem[w_idx] <= mem_wr.data;
    end

    // only word stores exist in this subset
    a_wr_aligned: assert property (
        @(posedge clk)
        mem_wr.en |-> mem_wr.addr[1:0] == 2'b00
    );

endmodule

//--- npc_top.sv
`timescale 1ns/1ps

module npc_top
    #(
        parameter npc_pkg::word_t reset_pc   = 32'h8000_0000,
        parameter int             dmem_words = 256
    )
    (
        input  logic             clk,
        input  logic             reset,
        input  npc_pkg::word_t   inst,
        output npc_pkg::word_t   pc,
        output npc_pkg::gpr_wr_t gpr_wr,
        output npc_pkg::mem_wr_t mem_wr,
        output logic             halted
    );

    import npc_pkg::*;

    inst_dec_t dec;
    word_t     src1;
    word_t     src2;
    word_t     alu_a;
    word_t     alu_b;
    alu_func_e alu_func;
    word_t     alu_result;
    word_t     mem_r_addr;
    word_t     mem_r;

    npc_idu npc_idu_inst
    (
        .inst (inst),
        .dec  (dec)
    );

    npc_gpr npc_gpr_inst
    (
        .clk    (clk),
        .reset  (reset),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .src1   (src1),
        .src2   (src2),
        .gpr_wr (gpr_wr)
    );

    npc_alu npc_alu_inst
    (
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_func   (alu_func),
        .alu_result (alu_result)
    );

    npc_exu #(.reset_pc(reset_pc)) npc_exu_inst
    (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .src1       (src1),
        .src2       (src2),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_func   (alu_func),
        .alu_result (alu_result),
        .mem_r_addr (mem_r_addr),
        .mem_r      (mem_r),
        .gpr_wr     (gpr_wr),
        .mem_wr     (mem_wr),
        .pc         (pc),
        .halted     (halted)
    );

    npc_dmem #(.dmem_words(dmem_words)) npc_dmem_inst
    (
        .clk        (clk),
        .mem_r_addr (mem_r_addr),
        .mem_r      (mem_r),
        .mem_wr     (mem_wr)
    );

endmodule

//--- tb_npc.sv
`timescale 1ns/1ps

module tb_npc;

    import npc_pkg::*;

    localparam word_t reset_pc    = 32'h8000_0000;
    localparam int    dmem_words  = 256;
    localparam word_t ebreak_inst = 32'h0010_0073;
    localparam word_t nop_inst    = 32'h0000_0013;   // addi x0, x0, 0
    localparam int    max_wait    = 100;

    logic    clk = 1'b0;
    logic    reset;
    word_t   inst;
    word_t   pc;
    gpr_wr_t gpr_wr;
    mem_wr_t mem_wr;
    logic    halted;

    // one entry per vector line
    string   names [$];
    word_t   insts [$];
    word_t   exp_pc [$];
    gpr_wr_t exp_gpr [$];
    mem_wr_t exp_mem [$];

    int error_count = 0;

    npc_top #(.reset_pc(reset_pc), .dmem_words(dmem_words)) npc_top_inst
    (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .pc     (pc),
        .gpr_wr (gpr_wr),
        .mem_wr (mem_wr),
        .halted (halted)
    );

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic load_vectors();
        int      fd;
        int      code;
        string   line;
        string   name;
        word_t   v_inst;
        word_t   v_pc;
        int      g_en;
        int      g_rd;
        word_t   g_data;
        int      m_en;
        word_t   m_addr;
        word_t   m_data;
        gpr_wr_t g;
        mem_wr_t m;
        fd = $fopen("npc_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the vector file npc_tests.txt");
            error_count++;
            stop_run();
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;   // blank or comment line
            code = $sscanf(line, "%s %h %h %d %d %h %d %h %h", name, v_inst, v_pc,
                           g_en, g_rd, g_data, m_en, m_addr, m_data);
            if (code != 9)
            begin
                $display("unreadable line in npc_tests.txt: %s", line);
                error_count++;
                stop_run();
            end
            g.en   = g_en[0];
            g.rd   = g_rd[4:0];
            g.data = g_data;
            m.en   = m_en[0];
            m.addr = m_addr;
            m.data = m_data;
            names.push_back(name);
            insts.push_back(v_inst);
            exp_pc.push_back(v_pc);
            exp_gpr.push_back(g);
            exp_mem.push_back(m);
        end
        $fclose(fd);
        if (names.size() == 0)
        begin
            $display("npc_tests.txt holds no test vectors");
            error_count++;
            stop_run();
        end
    endtask

    task automatic check_pc(string name, word_t expected, word_t actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %s: pc expected %h, actual %h", name, expected, actual);
            error_count++;
            stop_run();
        end
    endtask

    task automatic check_gpr_wr(string name, gpr_wr_t expected, gpr_wr_t actual);
        // rd and data only matter when a write happens
        if (actual.en !== expected.en ||
            (expected.en && (actual.rd !== expected.rd || actual.data !== expected.data)))
        begin
            $display("Mismatch in %s: gpr_wr expected %0b/%0d/%h, actual %0b/%0d/%h",
                     name, expected.en, expected.rd, expected.data,
                     actual.en, actual.rd, actual.data);
            error_count++;
            stop_run();
        end
    endtask

    task automatic check_mem_wr(string name, mem_wr_t expected, mem_wr_t actual);
        if (actual.en !== expected.en ||
            (expected.en && (actual.addr !== expected.addr || actual.data !== expected.data)))
        begin
            $display("Mismatch in %s: mem_wr expected %0b/%h/%h, actual %0b/%h/%h",
                     name, expected.en, expected.addr, expected.data,
                     actual.en, actual.addr, actual.data);
            error_count++;
            stop_run();
        end
    endtask

    task automatic check_halted(string name, logic expected, logic actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %s: halted expected %b, actual %b", name, expected, actual);
            error_count++;
            stop_run();
        end
    endtask

    initial
    begin
        int   cycles;
        logic halt_seen;
        reset     = 1'b1;
        inst      = nop_inst;
        halt_seen = 1'b0;
        load_vectors();

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        inst  <= insts[0];   // first vector runs in the cycle after reset

        cycles = 0;
        @(negedge clk);
        while (reset !== 1'b0 || halted !== 1'b0)
        begin
            if (cycles >= max_wait)
            begin
                $display("core did not leave reset within %0d cycles", max_wait);
                error_count++;
                stop_run();
            end
            cycles++;
            @(negedge clk);
        end

        for (int i = 0; i < names.size(); i++)
        begin
            if (i > 0)
            begin
                @(posedge clk);
                inst <= insts[i];
                @(negedge clk);   // outputs settled mid cycle
            end
            check_pc(names[i], exp_pc[i], pc);
            check_gpr_wr(names[i], exp_gpr[i], gpr_wr);
            check_mem_wr(names[i], exp_mem[i], mem_wr);
            check_halted(names[i], halt_seen, halted);
            if (insts[i] == ebreak_inst)
                halt_seen = 1'b1;
        end

        cycles = 0;
        while (halted !== 1'b1)
        begin
            if (cycles >= max_wait)
            begin
                $display("core did not halt within %0d cycles", max_wait);
                error_count++;
                stop_run();
            end
            cycles++;
            @(negedge clk);
        end

        if (error_count == 0)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Errors found");
            $fatal(1, "run ended with %0d errors", error_count);
        end
    end

endmodule

//--- npc_tests.txt
# name inst pc gpr_en gpr_rd gpr_data mem_en mem_addr mem_data
# inst, pc, data and addr are hex; en and rd are decimal; unused fields are 0
lui_x1          123450b7 80000000 1 1  12345000 0 00000000 00000000
addi_x1         67808093 80000004 1 1  12345678 0 00000000 00000000
auipc_x2        00001117 80000008 1 2  80001008 0 00000000 00000000
addi_neg_x3     fff00193 8000000c 1 3  ffffffff 0 00000000 00000000
addi_one_x4     00100213 80000010 1 4  00000001 0 00000000 00000000
add_wrap_x5     004182b3 80000014 1 5  00000000 0 00000000 00000000
sub_wrap_x6     40400333 80000018 1 6  ffffffff 0 00000000 00000000
add_to_x0       00408033 8000001c 1 0  12345679 0 00000000 00000000
add_x0_read     004003b3 80000020 1 7  00000001 0 00000000 00000000
addi_base_x8    10000413 80000024 1 8  00000100 0 00000000 00000000
sw_pos_offset   00142423 80000028 0 0  00000000 1 00000108 12345678
sw_neg_offset   fe642e23 8000002c 0 0  00000000 1 000000fc ffffffff
lw_pos_offset   00842483 80000030 1 9  12345678 0 00000000 00000000
lw_neg_offset   ffc42503 80000034 1 10 ffffffff 0 00000000 00000000
beq_taken       00438463 80000038 0 0  00000000 0 00000000 00000000
bne_not_taken   00439463 80000040 0 0  00000000 0 00000000 00000000
bne_taken       00419663 80000044 0 0  00000000 0 00000000 00000000
beq_not_taken   00418463 80000050 0 0  00000000 0 00000000 00000000
jal_fwd_x11     010005ef 80000054 1 11 80000058 0 00000000 00000000
lui_high_x12    80000637 80000064 1 12 80000000 0 00000000 00000000
jalr_odd_x13    079606e7 80000068 1 13 8000006c 0 00000000 00000000
jal_back_x14    ff9ff76f 80000078 1 14 8000007c 0 00000000 00000000
add_loaded_x15  00a487b3 80000070 1 15 12345677 0 00000000 00000000
ebreak_stop     00100073 80000074 0 0  00000000 0 00000000 00000000
halt_add_x16    00408833 80000078 0 0  00000000 0 00000000 00000000
halt_sw         00142023 80000078 0 0  00000000 0 00000000 00000000
halt_add_x17    004088b3 80000078 0 0  00000000 0 00000000 00000000
halt_sw_again   00142423 80000078 0 0  00000000 0 00000000 00000000

//--- files.f
npc_pkg.sv
npc_idu.sv
npc_gpr.sv
npc_alu.sv
npc_exu.sv
npc_dmem.sv
npc_top.sv
tb_npc.sv

//--- Bender.yml
package:
  name: npc

sources:
  - npc_pkg.sv
  - npc_idu.sv
  - npc_gpr.sv
  - npc_alu.sv
  - npc_exu.sv
  - npc_dmem.sv
  - npc_top.sv
  - target: test
    files:
      - tb_npc.sv
